/* flist.f */
+incdir+verification
src/sift_match_pkg.sv
src/stage_ifs.sv
src/pixel_locator.sv
src/descriptor_store.sv
src/descriptor_serializer.sv
src/sift_match_top.sv
verification/tb_sift_match.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then decide pass or fail from the log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sift_match \
  -f flist.f \
  -o tb_sift_match_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/tb_sift_match_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$SIM_LOG"; then
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$SIM_LOG"; then
  echo "simulation log has no result line"
  exit 1
fi
exit 0

/* verification/tb_ref_model.svh */
// included inside the testbench module after the package import; arrays hold at most 64 entries
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

  // ==================================================
  // descriptors as the stimulus wrote them
  // ==================================================
  localparam int REF_DEPTH = 64;

  desc_t book_ref  [REF_DEPTH];
  desc_t scene_ref [REF_DEPTH];
  int    book_total;
  int    scene_total;

  // next word the stream should carry
  int exp_book;
  int exp_scene;
  int exp_word;
  bit exp_is_scene;
  // set once every pair has gone out
  bit stream_done;

  // word k of a stored descriptor, low word first
  function automatic logic [WORD_W-1:0] ref_word(input bit is_scene, input int idx, input int k);
    desc_t d;
    d = is_scene ? scene_ref[idx] : book_ref[idx];
    return d[k*WORD_W +: WORD_W];
  endfunction

  // start of the pair walk
  function automatic void start_expected();
    exp_book     = 0;
    exp_scene    = 0;
    exp_word     = 0;
    exp_is_scene = 1'b0;
    // empty book or scene, nothing is streamed
    stream_done  = (book_total == 0) || (scene_total == 0);
  endfunction

  // book group, then every scene group, then next book
  function automatic void advance_expected();
    if (exp_word != DESC_WORDS - 1) begin
      exp_word = exp_word + 1;
    end else begin
      exp_word = 0;
      if (!exp_is_scene) begin
        exp_is_scene = 1'b1;
        exp_scene    = 0;
      end else if (exp_scene != scene_total - 1) begin
        exp_scene = exp_scene + 1;
      end else begin
        exp_is_scene = 1'b0;
        exp_scene    = 0;
        exp_book     = exp_book + 1;
        if (exp_book == book_total) begin
          stream_done = 1'b1;
        end
      end
    end
  endfunction

`endif

/* verification/tb_sift_match.sv */
// 16x12 frame, window 3..10 by 2..8, 64-deep memories; scene keypoints capped at 20 per frame
`timescale 1ns/100ps
`default_nettype none

module tb_sift_match;
  import sift_match_pkg::*;

  localparam int FRAME_W    = 16;
  localparam int FRAME_H    = 12;
  localparam int X_MIN      = 3;
  localparam int X_MAX      = 10;
  localparam int Y_MIN      = 2;
  localparam int Y_MAX      = 8;
  localparam int DEPTH      = 64;
  localparam int SCENE_CAP  = 20;
  localparam int WAIT_LIMIT = 5000;

  logic      CCD_PIXCLK;
  logic      DLY_RST_2;
  logic      i_pixel_valid;
  logic      i_is_keypoint;
  desc_t     i_descriptor;
  logic      i_learn_obj;
  logic      i_scene_wr_en;
  logic      i_pair_done;
  count_t    o_obj_count;
  count_t    o_scene_count;
  logic      o_obj_ready;
  logic      o_word_valid;
  word_t     o_word;
  word_idx_t o_word_idx;
  logic      o_word_is_scene;
  count_t    o_book_idx;
  count_t    o_scene_idx;
  logic      o_match_done;

  int seed;
  int errors;
  int checks;
  int hs_errors;
  int done_pulses;
  int err_before;
  bit checking;
  // last scene word seen, matcher not yet done
  bit pair_pending;

  `include "tb_ref_model.svh"

  sift_match_top #(
    .FRAME_W (FRAME_W), .FRAME_H (FRAME_H),
    .OBJ_X_MIN (X_MIN), .OBJ_X_MAX (X_MAX), .OBJ_Y_MIN (Y_MIN), .OBJ_Y_MAX (Y_MAX),
    .OBJ_DEPTH (DEPTH), .SCENE_DEPTH (DEPTH)
  ) uut (
    .CCD_PIXCLK (CCD_PIXCLK), .DLY_RST_2 (DLY_RST_2),
    .i_pixel_valid (i_pixel_valid), .i_is_keypoint (i_is_keypoint),
    .i_descriptor (i_descriptor), .i_learn_obj (i_learn_obj),
    .i_scene_wr_en (i_scene_wr_en), .i_pair_done (i_pair_done),
    .o_obj_count (o_obj_count), .o_scene_count (o_scene_count), .o_obj_ready (o_obj_ready),
    .o_word_valid (o_word_valid), .o_word (o_word), .o_word_idx (o_word_idx),
    .o_word_is_scene (o_word_is_scene), .o_book_idx (o_book_idx),
    .o_scene_idx (o_scene_idx), .o_match_done (o_match_done)
  );

  always #10 CCD_PIXCLK = ~CCD_PIXCLK;

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int bad);
    $display("test %s: %s, %0d errors", name, (bad == 0) ? "ok" : "mismatch", bad);
  endtask

  function automatic desc_t random_desc();
    desc_t d;
    for (int i = 0; i < DESC_W / 32; i++) begin
      d[i*32 +: 32] = $random(seed);
    end
    return d;
  endfunction

  // ==================================================
  // one raster frame with random gaps
  // ==================================================
  task automatic drive_frame(input bit learn, input bit scene_en);
    int    x;
    int    y;
    bit    kp;
    desc_t d;
    x = 0;
    y = 0;
    while (y < FRAME_H) begin
      @(posedge CCD_PIXCLK);
      #2;
      i_learn_obj   = learn;
      i_scene_wr_en = scene_en;
      if ($unsigned($random(seed)) % 4 == 0) begin
        i_pixel_valid = 1'b0;
        i_is_keypoint = 1'b0;
      end else begin
        d  = random_desc();
        kp = ($unsigned($random(seed)) % (learn ? 4 : 8)) == 0;
        // keep the scene well inside the memory
        if (scene_en && scene_total >= SCENE_CAP) begin
          kp = 1'b0;
        end
        i_pixel_valid = 1'b1;
        i_is_keypoint = kp;
        i_descriptor  = d;
        // object keypoints lie strictly inside the window
        if (kp && learn && x > X_MIN && x < X_MAX && y > Y_MIN && y < Y_MAX) begin
          book_ref[book_total] = d;
          book_total = book_total + 1;
        end
        if (kp && scene_en) begin
          scene_ref[scene_total] = d;
          scene_total = scene_total + 1;
        end
        x = x + 1;
        if (x == FRAME_W) begin
          x = 0;
          y = y + 1;
        end
      end
    end
    @(posedge CCD_PIXCLK);
    #2;
    i_pixel_valid = 1'b0;
    i_is_keypoint = 1'b0;
  endtask

  // ==================================================
  // matcher model, pair_done after 1 to 8 cycles
  // ==================================================
  task automatic run_pairs();
    int n;
    int d;
    for (int p = 0; p < book_total * scene_total; p++) begin
      n = 0;
      while (!pair_pending && n < WAIT_LIMIT) begin
        @(posedge CCD_PIXCLK);
        #2;
        n = n + 1;
      end
      if (!pair_pending) begin
        errors = errors + 1;
        $display("timeout: pair %0d never finished streaming", p);
        break;
      end
      d = 1 + $unsigned($random(seed)) % 8;
      repeat (d - 1) begin
        @(posedge CCD_PIXCLK);
        #2;
      end
      i_pair_done = 1'b1;
      @(posedge CCD_PIXCLK);
      #2;
      i_pair_done = 1'b0;
    end
    n = 0;
    while (done_pulses == 0 && n < WAIT_LIMIT) begin
      @(posedge CCD_PIXCLK);
      #2;
      n = n + 1;
    end
    if (done_pulses == 0) begin
      errors = errors + 1;
      $display("timeout: o_match_done never pulsed");
    end
  endtask

  // ==================================================
  // compare process, outputs are settled at the falling edge
  // ==================================================
  always @(negedge CCD_PIXCLK) begin
    if (DLY_RST_2 && checking) begin
      if (i_pair_done) begin
        pair_pending = 1'b0;
      end
      if (o_match_done) begin
        done_pulses = done_pulses + 1;
        // done only after the matcher released the last pair
        if (!stream_done || pair_pending || done_pulses > 1) begin
          errors    = errors + 1;
          hs_errors = hs_errors + 1;
          $display("ERR %0t: unexpected o_match_done pulse %0d", $time, done_pulses);
        end
      end
      if (o_word_valid) begin
        if (stream_done || done_pulses != 0) begin
          errors    = errors + 1;
          hs_errors = hs_errors + 1;
          $display("ERR %0t: word after the last pair", $time);
        end else begin
          if (o_word_idx == '0 && pair_pending) begin
            errors    = errors + 1;
            hs_errors = hs_errors + 1;
            $display("ERR %0t: descriptor started before pair done", $time);
          end
          check_value(o_word_is_scene, exp_is_scene, "word group kind");
          check_value(o_book_idx, exp_book, "book index");
          if (exp_is_scene) begin
            check_value(o_scene_idx, exp_scene, "scene index");
          end
          check_value(o_word_idx, exp_word, "word index");
          check_value(o_word, ref_word(exp_is_scene, exp_is_scene ? exp_scene : exp_book,
                                       exp_word), "word value");
          if (exp_is_scene && exp_word == DESC_WORDS - 1) begin
            pair_pending = 1'b1;
          end
          advance_expected();
        end
      end
    end
  end

  initial begin
    seed          = 32'h62c5;
    errors        = 0;
    checks        = 0;
    hs_errors     = 0;
    done_pulses   = 0;
    checking      = 1'b0;
    pair_pending  = 1'b0;
    book_total    = 0;
    scene_total   = 0;
    stream_done   = 1'b0;
    CCD_PIXCLK    = 1'b0;
    DLY_RST_2     = 1'b0;
    i_pixel_valid = 1'b0;
    i_is_keypoint = 1'b0;
    i_descriptor  = '0;
    i_learn_obj   = 1'b0;
    i_scene_wr_en = 1'b0;
    i_pair_done   = 1'b0;
    repeat (16) @(posedge CCD_PIXCLK);
    #2;
    DLY_RST_2 = 1'b1;

    // reset state
    err_before = errors;
    @(negedge CCD_PIXCLK);
    check_value(uut.f_if.wr_obj, 0, "wr_obj after reset");
    check_value(uut.f_if.wr_scene, 0, "wr_scene after reset");
    check_value(uut.f_if.match_start, 0, "match_start after reset");
    check_value(o_word_valid, 0, "o_word_valid after reset");
    check_value(o_obj_ready, 0, "o_obj_ready after reset");
    check_value(o_match_done, 0, "o_match_done after reset");
    check_value(o_obj_count, 0, "o_obj_count after reset");
    check_value(o_scene_count, 0, "o_scene_count after reset");
    report_test("1 reset", errors - err_before);

    // frame 1, learn the object
    err_before = errors;
    drive_frame(1'b1, 1'b0);
    @(negedge CCD_PIXCLK);
    check_value(o_obj_ready, 1, "o_obj_ready after frame 1");
    check_value(o_obj_count, book_total, "o_obj_count after frame 1");
    report_test("2 object capture", errors - err_before);

    // frame 2, scene writes; matching starts at its end
    err_before = errors;
    drive_frame(1'b0, 1'b1);
    start_expected();
    checking = 1'b1;
    @(negedge CCD_PIXCLK);
    check_value(o_scene_count, scene_total, "o_scene_count after frame 2");
    report_test("3 scene capture", errors - err_before);

    // frame 3 runs alongside the pair walk
    err_before = errors;
    fork
      drive_frame(1'b0, 1'b0);
      run_pairs();
    join
    // quiet window after the done pulse
    repeat (40) @(posedge CCD_PIXCLK);
    check_value(stream_done, 1, "every pair streamed");
    report_test("4 word stream", errors - err_before - hs_errors);
    check_value(done_pulses, 1, "o_match_done pulse count");
    report_test("5 pair handshake", hs_errors + ((done_pulses == 1) ? 0 : 1));

    $display("checks %0d, errors %0d, book %0d, scene %0d",
             checks, errors, book_total, scene_total);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/sift_match_top.sv */
// detector, descriptor generator and matcher are external; one clock, async active-low reset
`timescale 1ns/100ps
`default_nettype none

module sift_match_top #(
  parameter int FRAME_W     = sift_match_pkg::DEF_FRAME_W,
  parameter int FRAME_H     = sift_match_pkg::DEF_FRAME_H,
  parameter int OBJ_X_MIN   = sift_match_pkg::DEF_OBJ_X_MIN,
  parameter int OBJ_X_MAX   = sift_match_pkg::DEF_OBJ_X_MAX,
  parameter int OBJ_Y_MIN   = sift_match_pkg::DEF_OBJ_Y_MIN,
  parameter int OBJ_Y_MAX   = sift_match_pkg::DEF_OBJ_Y_MAX,
  parameter int OBJ_DEPTH   = 2048,
  parameter int SCENE_DEPTH = 2048
) (
  input  wire                        CCD_PIXCLK,
  input  wire                        DLY_RST_2,
  // pixel stream, all three in one cycle
  input  wire                        i_pixel_valid,
  input  wire                        i_is_keypoint,
  input  wire sift_match_pkg::desc_t i_descriptor,
  // mode levels
  input  wire                        i_learn_obj,
  input  wire                        i_scene_wr_en,
  // matcher finished a pair
  input  wire                        i_pair_done,
  output sift_match_pkg::count_t     o_obj_count,
  output sift_match_pkg::count_t     o_scene_count,
  output logic                       o_obj_ready,
  output logic                       o_word_valid,
  output sift_match_pkg::word_t      o_word,
  output sift_match_pkg::word_idx_t  o_word_idx,
  output logic                       o_word_is_scene,
  output sift_match_pkg::count_t     o_book_idx,
  output sift_match_pkg::count_t     o_scene_idx,
  output logic                       o_match_done
);

  feature_if f_if ();
  desc_rd_if rd_if ();

  // ==================================================
  // stages
  // ==================================================
  pixel_locator #(
    .FRAME_W   (FRAME_W),
    .FRAME_H   (FRAME_H),
    .OBJ_X_MIN (OBJ_X_MIN),
    .OBJ_X_MAX (OBJ_X_MAX),
    .OBJ_Y_MIN (OBJ_Y_MIN),
    .OBJ_Y_MAX (OBJ_Y_MAX)
  ) u_locator (
    .CCD_PIXCLK    (CCD_PIXCLK),
    .DLY_RST_2     (DLY_RST_2),
    .i_pixel_valid (i_pixel_valid),
    .i_is_keypoint (i_is_keypoint),
    .i_learn_obj   (i_learn_obj),
    .i_scene_wr_en (i_scene_wr_en),
    .o_obj_ready   (o_obj_ready),
    .f             (f_if.locator)
  );

  descriptor_store #(
    .OBJ_DEPTH   (OBJ_DEPTH),
    .SCENE_DEPTH (SCENE_DEPTH)
  ) u_store (
    .CCD_PIXCLK   (CCD_PIXCLK),
    .DLY_RST_2    (DLY_RST_2),
    .i_descriptor (i_descriptor),
    .f            (f_if.store),
    .rd           (rd_if.memory)
  );

  descriptor_serializer u_serializer (
    .CCD_PIXCLK      (CCD_PIXCLK),
    .DLY_RST_2       (DLY_RST_2),
    .i_pair_done     (i_pair_done),
    .f               (f_if.serializer),
    .rd              (rd_if.reader),
    .o_word_valid    (o_word_valid),
    .o_word          (o_word),
    .o_word_idx      (o_word_idx),
    .o_word_is_scene (o_word_is_scene),
    .o_book_idx      (o_book_idx),
    .o_scene_idx     (o_scene_idx),
    .o_match_done    (o_match_done)
  );

  // latched counts straight out
  assign o_obj_count   = f_if.obj_count;
  assign o_scene_count = f_if.scene_count;

endmodule

`default_nettype wire

/* src/descriptor_serializer.sv */
// counts are sampled at match_start; each scene descriptor waits for i_pair_done, no other stall
`timescale 1ns/100ps
`default_nettype none

module descriptor_serializer (
  input  wire                       CCD_PIXCLK,
  input  wire                       DLY_RST_2,
  input  wire                       i_pair_done,
  feature_if.serializer             f,
  desc_rd_if.reader                 rd,
  output logic                      o_word_valid,
  output sift_match_pkg::word_t     o_word,
  output sift_match_pkg::word_idx_t o_word_idx,
  output logic                      o_word_is_scene,
  output sift_match_pkg::count_t    o_book_idx,
  output sift_match_pkg::count_t    o_scene_idx,
  output logic                      o_match_done
);
  import sift_match_pkg::*;

  ser_state_e state;
  count_t     book_idx;
  count_t     scene_idx;
  count_t     book_last;
  count_t     scene_last;
  word_idx_t  word_idx;
  desc_t      cur_desc;
  logic       last_word;

  assign last_word = (word_idx == word_idx_t'(DESC_WORDS - 1));

  // ==================================================
  // pair walk FSM
  // ==================================================
  // outer loop over book, inner loop over scene
  always_ff @(posedge CCD_PIXCLK or negedge DLY_RST_2) begin
    if (!DLY_RST_2) begin
      state        <= SER_IDLE;
      book_idx     <= '0;
      scene_idx    <= '0;
      book_last    <= '0;
      scene_last   <= '0;
      word_idx     <= '0;
      o_match_done <= 1'b0;
    end else begin
      o_match_done <= 1'b0;
      case (state)
        SER_IDLE: begin
          if (f.match_start) begin
            // frame 3 may relatch scene_count while we run
            book_last  <= f.obj_count - 1'b1;
            scene_last <= f.scene_count - 1'b1;
            book_idx   <= '0;
            scene_idx  <= '0;
            // nothing to pair, finish at once
            if (f.obj_count == '0 || f.scene_count == '0) begin
              o_match_done <= 1'b1;
            end else begin
              state <= SER_READ_BOOK;
            end
          end
        end
        SER_READ_BOOK: begin
          word_idx <= '0;
          state    <= SER_SEND_BOOK;
        end
        SER_SEND_BOOK: begin
          word_idx <= word_idx + 1'b1;
          if (last_word) begin
            state <= SER_READ_SCENE;
          end
        end
        SER_READ_SCENE: begin
          word_idx <= '0;
          state    <= SER_SEND_SCENE;
        end
        SER_SEND_SCENE: begin
          word_idx <= word_idx + 1'b1;
          if (last_word) begin
            state <= SER_WAIT_PAIR;
          end
        end
        SER_WAIT_PAIR: begin
          // matcher back-pressure
          if (i_pair_done) begin
            if (scene_idx != scene_last) begin
              scene_idx <= scene_idx + 1'b1;
              state     <= SER_READ_SCENE;
            end else begin
              scene_idx <= '0;
              if (book_idx != book_last) begin
                book_idx <= book_idx + 1'b1;
                state    <= SER_READ_BOOK;
              end else begin
                o_match_done <= 1'b1;
                state        <= SER_IDLE;
              end
            end
          end
        end
        default: state <= SER_IDLE;
      endcase
    end
  end

  // ==================================================
  // memory reads and word output
  // ==================================================
  assign rd.rd_en      = (state == SER_READ_BOOK) || (state == SER_READ_SCENE);
  assign rd.book_addr  = book_idx;
  assign rd.scene_addr = scene_idx;

  assign o_word_valid    = (state == SER_SEND_BOOK) || (state == SER_SEND_SCENE);
  assign o_word_is_scene = (state == SER_SEND_SCENE);
  // read data holds until the next rd_en, so no local copy
  assign cur_desc        = o_word_is_scene ? rd.scene_desc : rd.book_desc;
  // word k is bits 40k+39:40k, low word first
  assign o_word          = cur_desc[word_idx * WORD_W +: WORD_W];
  assign o_word_idx      = word_idx;
  assign o_book_idx      = book_idx;
  assign o_scene_idx     = scene_idx;

  // idle and pair wait stay quiet into the next cycle too
  a_quiet_when_waiting: assert property (
    @(posedge CCD_PIXCLK) disable iff (!DLY_RST_2)
    state inside {SER_IDLE, SER_WAIT_PAIR} |=> !o_word_valid
  );

  // a burst only starts on data fetched from the store the cycle before
  a_read_before_burst: assert property (
    @(posedge CCD_PIXCLK) disable iff (!DLY_RST_2)
    o_word_valid && (o_word_idx == '0) |-> $past(rd.rd_en)
  );

endmodule

`default_nettype wire

/* src/descriptor_store.sv */
// depths must be powers of two no larger than 2**COUNT_W; memory contents are undefined after reset
`timescale 1ns/100ps
`default_nettype none

module descriptor_store #(
  parameter int OBJ_DEPTH   = 2048,
  parameter int SCENE_DEPTH = 2048
) (
  input  wire                   CCD_PIXCLK,
  input  wire                   DLY_RST_2,
  input  wire sift_match_pkg::desc_t i_descriptor,
  feature_if.store              f,
  desc_rd_if.memory             rd
);
  import sift_match_pkg::*;

  localparam int OBJ_AW   = $clog2(OBJ_DEPTH);
  localparam int SCENE_AW = $clog2(SCENE_DEPTH);

  desc_t desc_hold;
  desc_t obj_mem   [OBJ_DEPTH];
  desc_t scene_mem [SCENE_DEPTH];

  // ==================================================
  // alignment
  // ==================================================
  // strobes leave the locator one cycle late, so delay the descriptor too
  always_ff @(posedge CCD_PIXCLK) begin
    desc_hold <= i_descriptor;
  end

  // ==================================================
  // book and scene memories
  // ==================================================
  // one write port each, one shared read strobe
  always_ff @(posedge CCD_PIXCLK) begin
    if (f.wr_obj) begin
      obj_mem[f.obj_addr[OBJ_AW-1:0]] <= desc_hold;
    end
    if (f.wr_scene) begin
      scene_mem[f.scene_addr[SCENE_AW-1:0]] <= desc_hold;
    end
    // registered read, data lands the cycle after rd_en
    if (rd.rd_en) begin
      rd.book_desc  <= obj_mem[rd.book_addr[OBJ_AW-1:0]];
      rd.scene_desc <= scene_mem[rd.scene_addr[SCENE_AW-1:0]];
    end
  end

  // keypoint counts must never outgrow the memories
  a_addr_in_range: assert property (
    @(posedge CCD_PIXCLK) disable iff (!DLY_RST_2)
    (f.wr_obj |-> f.obj_addr < OBJ_DEPTH) and (f.wr_scene |-> f.scene_addr < SCENE_DEPTH)
  );

  // each keypoint is stored once, back-to-back writes must advance the address
  a_no_double_write: assert property (
    @(posedge CCD_PIXCLK) disable iff (!DLY_RST_2)
    (f.wr_obj && $past(f.wr_obj) |-> f.obj_addr != $past(f.obj_addr)) and
    (f.wr_scene && $past(f.wr_scene) |-> f.scene_addr != $past(f.scene_addr))
  );

endmodule

`default_nettype wire

/* src/pixel_locator.sv */
// assumes one valid pixel per raster position in order; object window bounds are exclusive
`timescale 1ns/100ps
`default_nettype none

module pixel_locator #(
  parameter int FRAME_W   = sift_match_pkg::DEF_FRAME_W,
  parameter int FRAME_H   = sift_match_pkg::DEF_FRAME_H,
  parameter int OBJ_X_MIN = sift_match_pkg::DEF_OBJ_X_MIN,
  parameter int OBJ_X_MAX = sift_match_pkg::DEF_OBJ_X_MAX,
  parameter int OBJ_Y_MIN = sift_match_pkg::DEF_OBJ_Y_MIN,
  parameter int OBJ_Y_MAX = sift_match_pkg::DEF_OBJ_Y_MAX
) (
  input  wire        CCD_PIXCLK,
  input  wire        DLY_RST_2,
  input  wire        i_pixel_valid,
  input  wire        i_is_keypoint,
  input  wire        i_learn_obj,
  input  wire        i_scene_wr_en,
  output logic       o_obj_ready,
  feature_if.locator f
);
  import sift_match_pkg::*;

  coord_t x;
  coord_t y;
  count_t obj_run;
  count_t obj_base;
  count_t scene_run;
  logic   learn_q;
  logic   learn_rise;
  logic   armed;
  logic   last_x;
  logic   frame_end;
  logic   in_window;
  logic   past_window;
  logic   capturing;
  logic   obj_hit;
  logic   scene_hit;

  // ==================================================
  // raster position
  // ==================================================
  assign last_x    = (x == coord_t'(FRAME_W - 1));
  assign frame_end = i_pixel_valid && last_x && (y == coord_t'(FRAME_H - 1));

  always_ff @(posedge CCD_PIXCLK or negedge DLY_RST_2) begin
    if (!DLY_RST_2) begin
      x <= '0;
      y <= '0;
    end else if (i_pixel_valid) begin
      if (last_x) begin
        x <= '0;
        y <= (y == coord_t'(FRAME_H - 1)) ? '0 : y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  // strictly inside the object square
  assign in_window = (x > coord_t'(OBJ_X_MIN)) && (x < coord_t'(OBJ_X_MAX)) &&
                     (y > coord_t'(OBJ_Y_MIN)) && (y < coord_t'(OBJ_Y_MAX));
  // below and right of it, the window is done
  assign past_window = (x > coord_t'(OBJ_X_MAX)) && (y > coord_t'(OBJ_Y_MAX));

  // ==================================================
  // object capture
  // ==================================================
  // a fresh learn level restarts the count in the same cycle
  assign learn_rise = i_learn_obj && !learn_q;
  assign obj_base   = learn_rise ? '0 : obj_run;
  assign capturing  = i_learn_obj && (learn_rise || !o_obj_ready);
  assign obj_hit    = i_pixel_valid && i_is_keypoint && capturing && in_window;

  always_ff @(posedge CCD_PIXCLK or negedge DLY_RST_2) begin
    if (!DLY_RST_2) begin
      learn_q       <= 1'b0;
      obj_run       <= '0;
      f.wr_obj      <= 1'b0;
      f.obj_addr    <= '0;
      f.obj_count   <= '0;
      f.match_start <= 1'b0;
      o_obj_ready   <= 1'b0;
      armed         <= 1'b0;
    end else begin
      learn_q  <= i_learn_obj;
      f.wr_obj <= obj_hit;
      if (obj_hit) begin
        f.obj_addr <= obj_base;
      end
      obj_run <= obj_base + count_t'(obj_hit);
      if (learn_rise) begin
        o_obj_ready <= 1'b0;
        armed       <= 1'b0;
      end
      if (capturing && i_pixel_valid && past_window) begin
        f.obj_count <= obj_base;
        o_obj_ready <= 1'b1;
        armed       <= 1'b1;
      end
      // armed implies ready, so one start per capture
      f.match_start <= frame_end && armed && !i_learn_obj;
      if (frame_end && armed && !i_learn_obj) begin
        armed <= 1'b0;
      end
    end
  end

  // ==================================================
  // scene capture
  // ==================================================
  assign scene_hit = i_pixel_valid && i_is_keypoint && i_scene_wr_en;

  always_ff @(posedge CCD_PIXCLK or negedge DLY_RST_2) begin
    if (!DLY_RST_2) begin
      scene_run     <= '0;
      f.wr_scene    <= 1'b0;
      f.scene_addr  <= '0;
      f.scene_count <= '0;
    end else begin
      f.wr_scene <= scene_hit;
      if (scene_hit) begin
        f.scene_addr <= scene_run;
      end
      // last pixel may itself be a keypoint
      if (frame_end) begin
        f.scene_count <= scene_run + count_t'(scene_hit);
        scene_run     <= '0;
      end else begin
        scene_run <= scene_run + count_t'(scene_hit);
      end
    end
  end

  // a start never lands inside a capture that is still learning
  a_no_start_while_learning: assert property (
    @(posedge CCD_PIXCLK) disable iff (!DLY_RST_2)
    f.match_start |-> o_obj_ready
  );

endmodule

`default_nettype wire

/* src/stage_ifs.sv */
// stage links; every feature_if signal is driven by the locator, read data lags rd_en by 1
`timescale 1ns/100ps
`default_nettype none

// ==================================================
// locator -> store / serializer
// ==================================================
interface feature_if;
  import sift_match_pkg::*;

  // single-cycle write strobes
  logic   wr_obj;
  logic   wr_scene;
  count_t obj_addr;
  count_t scene_addr;
  // counts latched at capture / frame end
  count_t obj_count;
  count_t scene_count;
  logic   match_start;

  modport locator (
    output wr_obj, wr_scene, obj_addr, scene_addr, obj_count, scene_count, match_start
  );
  modport store (input wr_obj, wr_scene, obj_addr, scene_addr);
  modport serializer (input obj_count, scene_count, match_start);
endinterface

// ==================================================
// serializer <-> descriptor memories
// ==================================================
interface desc_rd_if;
  import sift_match_pkg::*;

  logic   rd_en;
  count_t book_addr;
  count_t scene_addr;
  // valid the cycle after rd_en
  desc_t  book_desc;
  desc_t  scene_desc;

  modport reader (output rd_en, book_addr, scene_addr, input book_desc, scene_desc);
  modport memory (input rd_en, book_addr, scene_addr, output book_desc, scene_desc);
endinterface

`default_nettype wire

/* src/sift_match_pkg.sv */
// widths and defaults for the whole design; DESC_W must stay WORD_W * DESC_WORDS
`default_nettype none

package sift_match_pkg;

  // ==================================================
  // widths
  // ==================================================
  // one matcher word, 32 of them per descriptor
  localparam int WORD_W     = 40;
  localparam int DESC_WORDS = 32;
  localparam int DESC_W     = WORD_W * DESC_WORDS;
  localparam int COORD_W    = 10;
  // keypoint count, also the memory address
  localparam int COUNT_W    = 11;

  // ==================================================
  // default raster and object window
  // ==================================================
  localparam int DEF_FRAME_W   = 800;
  localparam int DEF_FRAME_H   = 600;
  // exclusive bounds, a keypoint on the edge is not part of the object
  localparam int DEF_OBJ_X_MIN = 336;
  localparam int DEF_OBJ_X_MAX = 464;
  localparam int DEF_OBJ_Y_MIN = 252;
  localparam int DEF_OBJ_Y_MAX = 380;

  typedef logic [COORD_W-1:0] coord_t;
  typedef logic [COUNT_W-1:0] count_t;
  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [DESC_W-1:0]  desc_t;
  typedef logic [4:0]         word_idx_t;

  // serializer FSM
  typedef enum logic [2:0] {
    SER_IDLE,
    SER_READ_BOOK,
    SER_SEND_BOOK,
    SER_READ_SCENE,
    SER_SEND_SCENE,
    SER_WAIT_PAIR
  } ser_state_e;

endpackage

`default_nettype wire
